/* hw/mmu_pkg.sv */
package mmu_pkg;

    // Sv32 address geometry
    localparam int VPN_W     = 20;
    localparam int PPN_W     = 22;
    localparam int PADDR_W   = 34;
    localparam int PTE_W     = 32;
    localparam int VPN_SEG_W = 10;   // One VPN level, also the superpage offset in pages

    // Flags returned with a translation, PTE bits 7:0
    localparam int FLAG_W = 8;

    // PTE flag positions
    localparam int PTE_V     = 0;
    localparam int PTE_R     = 1;
    localparam int PTE_W_BIT = 2;
    localparam int PTE_X     = 3;

    // First PPN bit inside a PTE
    localparam int PTE_PPN_LSB = 10;

    // Requester codes carried through lookup and walk
    localparam logic SRC_ITLB = 1'b0;
    localparam logic SRC_DTLB = 1'b1;

endpackage

/* hw/rr_arbiter.sv */
`timescale 1ns/1ps

module rr_arbiter #(
    parameter int N_REQ  = 2,
    parameter int DATA_W = 20,
    parameter int IDX_W  = (N_REQ > 1) ? $clog2(N_REQ) : 1
) (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic [N_REQ-1:0]        req_valid_i,
    input  logic [N_REQ*DATA_W-1:0] req_data_i,
    output logic [N_REQ-1:0]        req_ready_o,
    input  logic                    out_ready_i,
    output logic                    out_valid_o,
    output logic [DATA_W-1:0]       out_data_o,
    output logic [IDX_W-1:0]        out_idx_o
);

    logic [IDX_W-1:0] ptr;          // Highest priority requester this cycle
    logic [IDX_W-1:0] grant_idx;
    logic             grant_found;

    // First valid requester at or after the pointer, wrapping around
    always_comb begin
        int cand;
        grant_found = 1'b0;
        grant_idx   = '0;
        for (int i = 0; i < N_REQ; i++) begin
            cand = int'(ptr) + i;
            if (cand >= N_REQ) begin
                cand = cand - N_REQ;
            end
            if (!grant_found && req_valid_i[cand]) begin
                grant_found = 1'b1;
                grant_idx   = IDX_W'(cand);
            end
        end
    end

    // Idle requesters see ready so a new request is taken at once
    always_comb begin
        for (int i = 0; i < N_REQ; i++) begin
            req_ready_o[i] = out_ready_i & (~grant_found | (grant_idx == IDX_W'(i)));
        end
    end

    assign out_valid_o = grant_found;
    assign out_data_o  = req_data_i[grant_idx*DATA_W +: DATA_W];
    assign out_idx_o   = grant_idx;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ptr <= '0;
        end else if (out_valid_o && out_ready_i) begin
            ptr <= (grant_idx == IDX_W'(N_REQ - 1)) ? '0 : grant_idx + 1'b1;  // Skip past winner
        end
    end

endmodule

/* hw/tlb_cache.sv */
`timescale 1ns/1ps

module tlb_cache import mmu_pkg::*; #(
    parameter int TLB_ENTRIES = 8
) (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              lookup_valid_i,
    input  logic [VPN_W-1:0]  lookup_vpn_i,
    input  logic              lookup_src_i,
    output logic              lookup_ready_o,
    input  logic              busy_i,
    input  logic              refill_valid_i,
    input  logic [VPN_W-1:0]  refill_vpn_i,
    input  logic [PPN_W-1:0]  refill_ppn_i,
    input  logic              refill_super_i,
    input  logic [FLAG_W-1:0] refill_flags_i,
    input  logic              fence_i,
    input  logic              fence_all_i,
    input  logic [VPN_W-1:0]  fence_vpn_i,
    output logic              hit_valid_o,
    output logic              hit_src_o,
    output logic [PPN_W-1:0]  hit_ppn_o,
    output logic              hit_super_o,
    output logic [FLAG_W-1:0] hit_flags_o,
    output logic              walk_start_o,
    output logic [VPN_W-1:0]  walk_vpn_o,
    output logic              walk_src_o,
    output logic              fence_done_o
);

    localparam int IDX_W = $clog2(TLB_ENTRIES);

    logic [TLB_ENTRIES-1:0] ent_valid;
    logic [VPN_W-1:0]       ent_vpn   [TLB_ENTRIES];
    logic [PPN_W-1:0]       ent_ppn   [TLB_ENTRIES];
    logic                   ent_super [TLB_ENTRIES];
    logic [FLAG_W-1:0]      ent_flags [TLB_ENTRIES];
    logic [IDX_W-1:0]       victim;

    logic                   s1_valid;
    logic [VPN_W-1:0]       s1_vpn;
    logic                   s1_src;
    logic                   s1_hit;
    logic                   s1_miss;
    logic [IDX_W-1:0]       hit_idx;
    logic [PPN_W-1:0]       sel_ppn;

    logic                   fence_pend;
    logic                   fence_all_q;
    logic [VPN_W-1:0]       fence_vpn_q;
    logic                   fence_go;
    logic                   fence_all;
    logic [VPN_W-1:0]       fence_vpn;

    // A superpage entry only compares the upper VPN segment
    function automatic logic vpn_match(
        input logic [VPN_W-1:0] ent,
        input logic             sp,
        input logic [VPN_W-1:0] vpn
    );
        return (ent[VPN_W-1:VPN_SEG_W] == vpn[VPN_W-1:VPN_SEG_W]) &&
               (sp || (ent[VPN_SEG_W-1:0] == vpn[VPN_SEG_W-1:0]));
    endfunction

    always_comb begin
        s1_hit  = 1'b0;
        hit_idx = '0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (!s1_hit && ent_valid[i] && vpn_match(ent_vpn[i], ent_super[i], s1_vpn)) begin
                s1_hit  = 1'b1;
                hit_idx = IDX_W'(i);
            end
        end
    end

    assign s1_miss = s1_valid & ~s1_hit;
    assign sel_ppn = ent_super[hit_idx] ?
                     {ent_ppn[hit_idx][PPN_W-1:VPN_SEG_W], s1_vpn[VPN_SEG_W-1:0]} :
                     ent_ppn[hit_idx];

    // A pending miss blocks intake until the walker has finished
    assign lookup_ready_o = ~busy_i & ~walk_start_o & ~s1_miss & ~fence_pend & ~fence_i;

    assign fence_go  = (fence_i | fence_pend) & ~busy_i & ~walk_start_o & ~s1_miss;
    assign fence_all = fence_i ? fence_all_i : fence_all_q;
    assign fence_vpn = fence_i ? fence_vpn_i : fence_vpn_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            s1_valid     <= 1'b0;
            hit_valid_o  <= 1'b0;
            walk_start_o <= 1'b0;
            fence_pend   <= 1'b0;
            fence_done_o <= 1'b0;
        end else begin
            s1_valid     <= lookup_valid_i & lookup_ready_o;
            hit_valid_o  <= s1_valid & s1_hit;
            walk_start_o <= s1_miss;
            fence_pend   <= (fence_pend | fence_i) & ~fence_go;
            fence_done_o <= fence_go;
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_valid_i && lookup_ready_o) begin
            s1_vpn <= lookup_vpn_i;
            s1_src <= lookup_src_i;
        end
        hit_src_o   <= s1_src;
        hit_ppn_o   <= sel_ppn;
        hit_super_o <= ent_super[hit_idx];
        hit_flags_o <= ent_flags[hit_idx];
        walk_vpn_o  <= s1_vpn;
        walk_src_o  <= s1_src;
        if (fence_i) begin
            fence_all_q <= fence_all_i;
            fence_vpn_q <= fence_vpn_i;
        end
    end

    always_ff @(posedge clk) begin
        if (refill_valid_i) begin
            ent_vpn[victim]   <= refill_vpn_i;
            ent_ppn[victim]   <= refill_ppn_i;
            ent_super[victim] <= refill_super_i;
            ent_flags[victim] <= refill_flags_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ent_valid <= '0;
            victim    <= '0;
        end else begin
            if (refill_valid_i) begin
                ent_valid[victim] <= 1'b1;
                victim            <= victim + 1'b1;  // Round-robin replacement
            end
            if (fence_go) begin
                for (int i = 0; i < TLB_ENTRIES; i++) begin
                    if (fence_all || vpn_match(ent_vpn[i], ent_super[i], fence_vpn)) begin
                        ent_valid[i] <= 1'b0;
                    end
                end
            end
        end
    end

endmodule

/* hw/page_walker.sv */
`timescale 1ns/1ps

module page_walker import mmu_pkg::*; (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               start_i,
    input  logic [VPN_W-1:0]   vpn_i,
    input  logic               src_i,
    input  logic [PPN_W-1:0]   satp_ppn_i,
    output logic               busy_o,
    output logic               mem_req_o,
    output logic [PADDR_W-1:0] mem_addr_o,
    input  logic               mem_ready_i,
    input  logic               mem_rvalid_i,
    input  logic [PTE_W-1:0]   mem_rdata_i,
    output logic               result_valid_o,
    input  logic               result_ready_i,
    output logic [VPN_W-1:0]   result_vpn_o,
    output logic               result_src_o,
    output logic [PPN_W-1:0]   result_ppn_o,
    output logic               result_super_o,
    output logic [FLAG_W-1:0]  result_flags_o,
    output logic               result_fault_o
);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_REQ  = 2'd1;
    localparam logic [1:0] ST_WAIT = 2'd2;
    localparam logic [1:0] ST_DONE = 2'd3;

    logic [1:0]         state;
    logic               level;      // 1 while reading the root table
    logic [PADDR_W-1:0] addr_q;

    logic [PPN_W-1:0]   pte_ppn;
    logic               pte_v;
    logic               pte_r;
    logic               pte_w;
    logic               pte_x;
    logic               pte_bad;
    logic               pte_leaf;
    logic               next_level;

    assign pte_ppn  = mem_rdata_i[PTE_PPN_LSB +: PPN_W];
    assign pte_v    = mem_rdata_i[PTE_V];
    assign pte_r    = mem_rdata_i[PTE_R];
    assign pte_w    = mem_rdata_i[PTE_W_BIT];
    assign pte_x    = mem_rdata_i[PTE_X];
    assign pte_bad  = ~pte_v | (pte_w & ~pte_r);
    assign pte_leaf = pte_r | pte_x;

    // Valid pointer at the root level continues the walk
    assign next_level = ~pte_bad & ~pte_leaf & level;

    assign busy_o         = (state != ST_IDLE);
    assign mem_req_o      = (state == ST_REQ);
    assign mem_addr_o     = addr_q;
    assign result_valid_o = (state == ST_DONE);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state <= ST_IDLE;
            level <= 1'b1;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start_i) begin
                        state <= ST_REQ;
                        level <= 1'b1;
                    end
                end
                ST_REQ: begin
                    if (mem_ready_i) begin
                        state <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (mem_rvalid_i) begin
                        state <= next_level ? ST_REQ : ST_DONE;
                        level <= level & ~next_level;
                    end
                end
                default: begin
                    if (result_ready_i) begin
                        state <= ST_IDLE;  // Result taken
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && start_i) begin
            result_vpn_o <= vpn_i;
            result_src_o <= src_i;
            addr_q       <= {satp_ppn_i, vpn_i[VPN_W-1 -: VPN_SEG_W], 2'b00};
        end
        if (state == ST_WAIT && mem_rvalid_i) begin
            result_flags_o <= mem_rdata_i[FLAG_W-1:0];
            result_super_o <= level;
            result_ppn_o   <= pte_ppn;
            result_fault_o <= 1'b0;
            if (pte_bad) begin
                result_fault_o <= 1'b1;
            end else if (!pte_leaf) begin
                if (level) begin
                    addr_q <= {pte_ppn, result_vpn_o[VPN_SEG_W-1:0], 2'b00};
                end else begin
                    result_fault_o <= 1'b1;  // Pointer at the last level
                end
            end else if (level) begin
                // Superpage must be aligned, page offset comes from the VPN
                result_fault_o <= (pte_ppn[VPN_SEG_W-1:0] != '0);
                result_ppn_o   <= {pte_ppn[PPN_W-1:VPN_SEG_W], result_vpn_o[VPN_SEG_W-1:0]};
            end
        end
    end

endmodule

/* hw/l2_tlb.sv */
`timescale 1ns/1ps

module l2_tlb import mmu_pkg::*; #(
    parameter int TLB_ENTRIES = 8
) (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               itlb_req_i,
    input  logic [VPN_W-1:0]   itlb_vpn_i,
    output logic               itlb_ready_o,
    input  logic               dtlb_req_i,
    input  logic [VPN_W-1:0]   dtlb_vpn_i,
    output logic               dtlb_ready_o,
    output logic               itlb_resp_valid_o,
    output logic               dtlb_resp_valid_o,
    output logic [PPN_W-1:0]   resp_ppn_o,
    output logic               resp_super_o,
    output logic [FLAG_W-1:0]  resp_flags_o,
    output logic               resp_fault_o,
    input  logic [PPN_W-1:0]   satp_ppn_i,
    input  logic               fence_i,
    input  logic               fence_all_i,
    input  logic [VPN_W-1:0]   fence_vpn_i,
    output logic               fence_done_o,
    output logic               mem_req_o,
    output logic [PADDR_W-1:0] mem_addr_o,
    input  logic               mem_ready_i,
    input  logic               mem_rvalid_i,
    input  logic [PTE_W-1:0]   mem_rdata_i
);

    logic              fence_q;
    logic              arb_valid;
    logic              arb_ready;
    logic [VPN_W-1:0]  arb_vpn;
    logic [0:0]        arb_idx;
    logic              cache_ready;

    logic              hit_valid;
    logic              hit_src;
    logic [PPN_W-1:0]  hit_ppn;
    logic              hit_super;
    logic [FLAG_W-1:0] hit_flags;
    logic              walk_start;
    logic [VPN_W-1:0]  walk_vpn;
    logic              walk_src;

    logic              walk_busy;
    logic              walk_valid;
    logic              walk_ready;
    logic              walk_xfer;
    logic [VPN_W-1:0]  res_vpn;
    logic              res_src;
    logic [PPN_W-1:0]  res_ppn;
    logic              res_super;
    logic [FLAG_W-1:0] res_flags;
    logic              res_fault;

    logic              resp_valid;
    logic              resp_src;

    assign arb_ready = cache_ready & ~fence_q;  // Fence holds both requesters off

    rr_arbiter #(.N_REQ(2), .DATA_W(VPN_W)) u_arb (
        .clk        (clk),
        .reset_i    (reset_i),
        .req_valid_i({dtlb_req_i, itlb_req_i}),
        .req_data_i ({dtlb_vpn_i, itlb_vpn_i}),
        .req_ready_o({dtlb_ready_o, itlb_ready_o}),
        .out_ready_i(arb_ready),
        .out_valid_o(arb_valid),
        .out_data_o (arb_vpn),
        .out_idx_o  (arb_idx)
    );

    tlb_cache #(.TLB_ENTRIES(TLB_ENTRIES)) u_cache (
        .clk           (clk),
        .reset_i       (reset_i),
        .lookup_valid_i(arb_valid & ~fence_q),
        .lookup_vpn_i  (arb_vpn),
        .lookup_src_i  ((arb_idx == 1'b0) ? SRC_ITLB : SRC_DTLB),
        .lookup_ready_o(cache_ready),
        .busy_i        (walk_busy),
        .refill_valid_i(walk_xfer & ~res_fault),  // Faults are never cached
        .refill_vpn_i  (res_vpn),
        .refill_ppn_i  (res_ppn),
        .refill_super_i(res_super),
        .refill_flags_i(res_flags),
        .fence_i       (fence_i),
        .fence_all_i   (fence_all_i),
        .fence_vpn_i   (fence_vpn_i),
        .hit_valid_o   (hit_valid),
        .hit_src_o     (hit_src),
        .hit_ppn_o     (hit_ppn),
        .hit_super_o   (hit_super),
        .hit_flags_o   (hit_flags),
        .walk_start_o  (walk_start),
        .walk_vpn_o    (walk_vpn),
        .walk_src_o    (walk_src),
        .fence_done_o  (fence_done_o)
    );

    page_walker u_walker (
        .clk           (clk),
        .reset_i       (reset_i),
        .start_i       (walk_start),
        .vpn_i         (walk_vpn),
        .src_i         (walk_src),
        .satp_ppn_i    (satp_ppn_i),
        .busy_o        (walk_busy),
        .mem_req_o     (mem_req_o),
        .mem_addr_o    (mem_addr_o),
        .mem_ready_i   (mem_ready_i),
        .mem_rvalid_i  (mem_rvalid_i),
        .mem_rdata_i   (mem_rdata_i),
        .result_valid_o(walk_valid),
        .result_ready_i(walk_ready),
        .result_vpn_o  (res_vpn),
        .result_src_o  (res_src),
        .result_ppn_o  (res_ppn),
        .result_super_o(res_super),
        .result_flags_o(res_flags),
        .result_fault_o(res_fault)
    );

    // Hits own the response bus, the walker waits
    assign walk_ready = ~hit_valid;
    assign walk_xfer  = walk_valid & walk_ready;
    assign resp_valid = hit_valid | walk_xfer;
    assign resp_src   = hit_valid ? hit_src : res_src;

    assign itlb_resp_valid_o = resp_valid & (resp_src == SRC_ITLB);
    assign dtlb_resp_valid_o = resp_valid & (resp_src == SRC_DTLB);
    assign resp_ppn_o        = hit_valid ? hit_ppn : res_ppn;
    assign resp_super_o      = hit_valid ? hit_super : res_super;
    assign resp_flags_o      = hit_valid ? hit_flags : res_flags;
    assign resp_fault_o      = ~hit_valid & res_fault;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            fence_q <= 1'b0;
        end else begin
            fence_q <= fence_i | (fence_q & ~fence_done_o);
        end
    end

endmodule

/* tests/l2_tlb_props.sv */
`timescale 1ns/1ps

module l2_tlb_props import mmu_pkg::*; (
    input logic               clk,
    input logic               reset_i,
    input logic               itlb_resp_valid_o,
    input logic               dtlb_resp_valid_o,
    input logic               itlb_ready_o,
    input logic               dtlb_ready_o,
    input logic               mem_req_o,
    input logic [PADDR_W-1:0] mem_addr_o,
    input logic               mem_ready_i,
    input logic               fence_i,
    input logic               fence_done_o
);

    logic fence_seen;  // Fence accepted and not yet completed

    always_ff @(posedge clk) begin
        if (reset_i) begin
            fence_seen <= 1'b0;
        end else begin
            fence_seen <= fence_i | (fence_seen & ~fence_done_o);
        end
    end

    assert property (@(posedge clk) disable iff (reset_i)
        !(itlb_resp_valid_o && dtlb_resp_valid_o))
        else $error("both response valids high");

    assert property (@(posedge clk) disable iff (reset_i)
        mem_req_o && !mem_ready_i |=> mem_req_o && $stable(mem_addr_o))
        else $error("memory request changed before ready");

    assert property (@(posedge clk) disable iff (reset_i)
        (fence_i || fence_seen) |-> !itlb_ready_o && !dtlb_ready_o)
        else $error("request ready high during fence");

    // Registers settle on the first reset edge
    assert property (@(posedge clk)
        reset_i |=> !itlb_resp_valid_o && !dtlb_resp_valid_o)
        else $error("response valid during reset");

endmodule

bind l2_tlb l2_tlb_props u_props (.*);

/* tests/l2_tlb_tb.sv */
`timescale 1ns/1ps

module l2_tlb_tb;
    import mmu_pkg::*;

    localparam int TIMEOUT = 500;            // Cycles allowed for any single wait

    logic               clk;
    logic               reset_i;
    logic               itlb_req_i;
    logic [VPN_W-1:0]   itlb_vpn_i;
    logic               itlb_ready_o;
    logic               dtlb_req_i;
    logic [VPN_W-1:0]   dtlb_vpn_i;
    logic               dtlb_ready_o;
    logic               itlb_resp_valid_o;
    logic               dtlb_resp_valid_o;
    logic [PPN_W-1:0]   resp_ppn_o;
    logic               resp_super_o;
    logic [FLAG_W-1:0]  resp_flags_o;
    logic               resp_fault_o;
    logic [PPN_W-1:0]   satp_ppn_i;
    logic               fence_i;
    logic               fence_all_i;
    logic [VPN_W-1:0]   fence_vpn_i;
    logic               fence_done_o;
    logic               mem_req_o;
    logic [PADDR_W-1:0] mem_addr_o;
    logic               mem_ready_i;
    logic               mem_rvalid_i;
    logic [PTE_W-1:0]   mem_rdata_i;

    logic [PTE_W-1:0]   mem [logic [31:0]];  // Word addressed page tables
    int                 reads_served;

    l2_tlb #(.TLB_ENTRIES(8)) DUT (.*);

    always #50 clk = ~clk;

    task automatic fail_now(input string what);
        $display("Errors found");
        $fatal(1, "%s", what);
    endtask

    task automatic check_ppn(input string name, input logic [PPN_W-1:0] exp,
                             input logic [PPN_W-1:0] act);
        if (act !== exp) begin
            $display("FAIL %s ppn: expected %h, actual %h", name, exp, act);
            fail_now("translation PPN mismatch");
        end
    endtask

    task automatic check_flags(input string name, input logic [FLAG_W-1:0] exp,
                               input logic [FLAG_W-1:0] act);
        if (act !== exp) begin
            $display("FAIL %s flags: expected %h, actual %h", name, exp, act);
            fail_now("translation flags mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL %s: expected %b, actual %b", name, exp, act);
            fail_now("response bit mismatch");
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("FAIL %s reads: expected %0d, actual %0d", name, exp, act);
            fail_now("memory read count mismatch");
        end
    endtask

    // Memory model serving one read at a time after a random ready delay
    always begin
        int          delay;
        logic [31:0] waddr;
        @(posedge clk);
        if (!reset_i && mem_req_o) begin
            delay = int'($urandom_range(3, 0));
            repeat (delay) @(posedge clk);
            waddr = mem_addr_o[PADDR_W-1:2];
            #5 mem_ready_i = 1'b1;
            @(posedge clk);
            #5 mem_ready_i = 1'b0;
            mem_rvalid_i = 1'b1;
            mem_rdata_i  = mem.exists(waddr) ? mem[waddr] : '0;
            reads_served++;
            @(posedge clk);
            #5 mem_rvalid_i = 1'b0;
        end
    end

    // One request on one side that waits for acceptance and then its own response
    task automatic request_translation(input string name, input logic side,
                              input logic [VPN_W-1:0] vpn, input logic [PPN_W-1:0] e_ppn,
                              input logic e_super, input logic [FLAG_W-1:0] e_flags,
                              input logic e_fault, input logic solo);
        int   n;
        logic rdy;
        logic got;
        @(posedge clk);
        #5;
        if (side) begin
            dtlb_req_i = 1'b1;
            dtlb_vpn_i = vpn;
        end else begin
            itlb_req_i = 1'b1;
            itlb_vpn_i = vpn;
        end
        n = 0;
        forever begin
            #1 rdy = side ? dtlb_ready_o : itlb_ready_o;
            @(posedge clk);
            if (rdy) break;
            n++;
            if (n > TIMEOUT) fail_now("request was never accepted");
            #5;
        end
        #5;
        if (side) dtlb_req_i = 1'b0;
        else itlb_req_i = 1'b0;
        got = 1'b0;
        n   = 0;
        while (!got) begin
            @(posedge clk);
            #1;
            if (solo && (side ? itlb_resp_valid_o : dtlb_resp_valid_o)) begin
                fail_now("response arrived on the wrong requester");
            end
            got = side ? dtlb_resp_valid_o : itlb_resp_valid_o;
            n++;
            if (n > TIMEOUT) fail_now("no response from the DUT");
        end
        check_bit(name, e_fault, resp_fault_o);
        if (!e_fault) begin                   // Fault results carry no translation
            check_ppn(name, e_ppn, resp_ppn_o);
            check_bit(name, e_super, resp_super_o);
            check_flags(name, e_flags, resp_flags_o);
        end
        @(posedge clk);
        #1;
        if (side ? dtlb_resp_valid_o : itlb_resp_valid_o) begin
            fail_now("response valid stayed high for more than one cycle");
        end
    endtask

    task automatic send_fence(input logic all, input logic [VPN_W-1:0] vpn);
        int   n;
        logic done;
        @(posedge clk);
        #5 fence_i = 1'b1;
        fence_all_i = all;
        fence_vpn_i = vpn;
        @(posedge clk);
        #1 done = fence_done_o;
        #4 fence_i = 1'b0;
        n = 0;
        while (!done) begin
            @(posedge clk);
            #1 done = fence_done_o;
            n++;
            if (n > TIMEOUT) fail_now("fence was never completed");
        end
    endtask

    initial begin
        int                fd;
        int                code;
        string             tok;
        string             name;
        string             rest;
        logic [31:0]       a;
        logic [31:0]       d;
        logic              src;
        logic              sup;
        logic              flt;
        logic              all;
        logic [VPN_W-1:0]  vpn;
        logic [VPN_W-1:0]  vpn2;
        logic [PPN_W-1:0]  ppn;
        logic [PPN_W-1:0]  ppn2;
        logic [FLAG_W-1:0] flg;
        logic [FLAG_W-1:0] flg2;
        int                reads;
        clk          = 1'b0;
        reset_i      = 1'b1;
        itlb_req_i   = 1'b0;
        itlb_vpn_i   = '0;
        dtlb_req_i   = 1'b0;
        dtlb_vpn_i   = '0;
        satp_ppn_i   = '0;
        fence_i      = 1'b0;
        fence_all_i  = 1'b0;
        fence_vpn_i  = '0;
        mem_ready_i  = 1'b0;
        mem_rvalid_i = 1'b0;
        mem_rdata_i  = '0;
        reads_served = 0;
        void'($urandom(32'h6dc6));
        fd = $fopen("tests/l2_tlb_trace.txt", "r");
        if (fd == 0) fail_now("cannot open the trace file");
        repeat (16) @(posedge clk);
        #5 reset_i = 1'b0;
        while ($fscanf(fd, " %s", tok) == 1) begin
            if (tok[0] == "#") begin
                code = $fgets(rest, fd);      // Skip comment text
            end else if (tok == "M") begin
                code = $fscanf(fd, " %h %h", a, d);
                mem[a] = d;
            end else if (tok == "S") begin
                code = $fscanf(fd, " %h", ppn);
                satp_ppn_i = ppn;
            end else if (tok == "R") begin
                code = $fscanf(fd, " %s %h %h %h %h %h %h %d",
                               name, src, vpn, ppn, sup, flg, flt, reads);
                if (code != 8) fail_now("malformed request line in trace");
                reads_served = 0;
                request_translation(name, src, vpn, ppn, sup, flg, flt, 1'b1);
                check_count(name, reads, reads_served);
            end else if (tok == "P") begin
                code = $fscanf(fd, " %s %h %h %h %h %h %h",
                               name, vpn, ppn, flg, vpn2, ppn2, flg2);
                if (code != 7) fail_now("malformed paired line in trace");
                fork
                    request_translation(name, SRC_ITLB, vpn, ppn, 1'b0, flg, 1'b0, 1'b0);
                    request_translation(name, SRC_DTLB, vpn2, ppn2, 1'b0, flg2, 1'b0, 1'b0);
                join
            end else if (tok == "F") begin
                code = $fscanf(fd, " %s %h %h", name, all, vpn);
                send_fence(all, vpn);
            end else begin
                fail_now("unknown line type in trace");
            end
        end
        $fclose(fd);
        $display("No errors");
        $finish;
    end

endmodule

/* tests/l2_tlb_trace.txt */
# M word_addr pte | S satp_ppn | F name all vpn
# R name src vpn ppn super flags fault reads | P name ivpn ippn iflags dvpn dppn dflags
M 40001 00040401
M 40401 008d14cf
M 40402 008d1847
M 40403 00c0004b
M 40002 001000cb
M 40004 0010040b
S 000100
R page_miss 0 00401 002345 0 cf 0 2
R page_hit 0 00401 002345 0 cf 0 0
R page_hit_d 1 00401 002345 0 cf 0 0
R super_miss 1 00805 000405 1 cb 0 1
R super_hit 0 00a10 000610 1 cb 0 0
R bad_pte 1 00c00 000000 0 00 1 1
R bad_pte_again 1 00c00 000000 0 00 1 1
R misaligned 0 01000 000000 0 00 1 1
R misaligned_again 0 01000 000000 0 00 1 1
P pair_miss 00403 003000 4b 00402 002346 47
P pair_hit 00403 003000 4b 00402 002346 47
F fence_one 0 00401
R after_fence_one 0 00401 002345 0 cf 0 2
R other_kept 1 00805 000405 1 cb 0 0
F fence_all 1 00000
R after_all_a 0 00401 002345 0 cf 0 2
R after_all_b 1 00a10 000610 1 cb 0 1
R after_all_c 1 00403 003000 0 4b 0 2
R after_all_c_hit 0 00403 003000 0 4b 0 0

/* files.f */
hw/mmu_pkg.sv
hw/rr_arbiter.sv
hw/tlb_cache.sv
hw/page_walker.sv
hw/l2_tlb.sv
tests/l2_tlb_props.sv
tests/l2_tlb_tb.sv

/* Makefile */
# Verilator build and run for the L2 TLB testbench

VERILATOR ?= verilator
TOP       ?= l2_tlb_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "No errors" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
